/* vlog.f */
hdl/ps2_kbd_pkg.sv
hdl/ps2_frame_rx.sv
hdl/ps2_idle_timer.sv
hdl/make_break_fsm.sv
hdl/key_fifo.sv
hdl/key_display.sv
hdl/ps2_kbd_top.sv
tb/ps2_kbd_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ps2_kbd_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/ps2_kbd_tb.sv */
module ps2_kbd_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF         = 10;  // clk cycles per ps2 half period.
    localparam int SETTLE       = 8;
    localparam int FRAME_CYCLES = 22 * HALF + SETTLE;
    localparam int IDLE_HOLD    = 300;
    localparam int MAX_FRAMES   = 500;
    localparam int MAX_POPS     = 180;
    localparam int LIMIT = (MAX_FRAMES * FRAME_CYCLES + MAX_POPS * (SETTLE + 2)
                            + IDLE_HOLD + 10) * 3 / 2;

    // active-low glyphs 0 to F, bit 6 is segment a.
    localparam logic [6:0] SEG_PAT [16] = '{7'h01, 7'h4F, 7'h12, 7'h06, 7'h4C, 7'h24, 7'h60, 7'h0F,
                                            7'h00, 7'h0C, 7'h08, 7'h60, 7'h31, 7'h42, 7'h30, 7'h38};
    // scan set 2 codes for 0 to 9, then A to Z.
    localparam logic [7:0] KEYS [36] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D,
                                         8'h3E, 8'h46, 8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B,
                                         8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31,
                                         8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A,
                                         8'h1D, 8'h22, 8'h35, 8'h1A};

    logic                    clk;
    logic                    rst_n;
    logic                    ps2_clk;
    logic                    ps2_data;
    logic                    pop;
    ps2_kbd_pkg::scan_code_t key_code;
    logic                    ready;
    logic                    overflow;
    ps2_kbd_pkg::seg_bank_t  segs;

    integer     seed = 32'h6895;
    int         cycles;
    int         errors;
    int         test_start;
    int         tests_run;
    int         tests_bad;
    int         disp_checks;
    int         disp_errors;
    logic [7:0] exp_q [$];  // model of the queue.
    logic [7:0] last_make;
    logic       brk_after;
    logic       in_break;
    logic       rel;
    logic       exp_ovf;
    int         count;

    ps2_kbd_top #(.FIFO_DEPTH(8), .IDLE_CYCLES(200)) ps2_kbd_top_inst (
        .clk(clk), .rst_n(rst_n), .ps2_clk(ps2_clk), .ps2_data(ps2_data), .pop(pop),
        .key_code(key_code), .ready(ready), .overflow(overflow), .segs(segs)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic int rand_below(int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic logic [7:0] random_key();
        logic [7:0] code;
        if (rand_below(2) == 0)
            return KEYS[rand_below(36)];
        code = 8'(rand_below(256));
        return (code == 8'hF0) ? 8'h29 : code;  // never a break prefix.
    endfunction

    function automatic logic [7:0] model_ascii(logic [7:0] code);
        for (int i = 0; i < 36; i++) begin
            if (KEYS[i] == code)
                return (i < 10) ? 8'(48 + i) : 8'(55 + i);
        end
        return 8'd0;
    endfunction

    function automatic ps2_kbd_pkg::seg_bank_t model_segs();
        ps2_kbd_pkg::seg_bank_t s;
        logic [7:0]             head;
        logic [7:0]             asc;
        s = '1;
        if (!rel && exp_q.size() > 0) begin
            head       = exp_q[0];
            asc        = 8'(model_ascii(head) % 100);
            s.hex_lo   = SEG_PAT[head[3:0]];
            s.hex_hi   = SEG_PAT[head[7:4]];
            s.asc_ones = SEG_PAT[asc % 10];
            s.asc_tens = SEG_PAT[asc / 10];
        end
        s.cnt_ones = SEG_PAT[count % 10];
        s.cnt_tens = SEG_PAT[count / 10];
        return s;
    endfunction

    // bad: 1 parity, 2 start bit, 3 stop bit.
    function automatic logic [10:0] frame_bits(logic [7:0] code, int bad);
        logic [10:0] f;
        f = {1'b1, ~^code, code, 1'b0};
        if (bad == 1)
            f[9] = ~f[9];
        if (bad == 2)
            f[0] = 1'b1;
        if (bad == 3)
            f[10] = 1'b0;
        return f;
    endfunction

    task automatic report_value(string name, logic [63:0] exp, logic [63:0] act);
        $display("Fail %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    task automatic report_error(string msg);
        $display("Error: %s", msg);
        errors++;
    endtask

    task automatic model_frame(logic [7:0] code);
        if (in_break) begin
            in_break = 1'b0;  // released key is swallowed.
        end else if (code == 8'hF0) begin
            in_break  = 1'b1;
            rel       = 1'b1;
            brk_after = 1'b1;
        end else begin
            if (exp_q.size() < 8)
                exp_q.push_back(code);
            else
                exp_ovf = 1'b1;
            if ((code != last_make || brk_after) && count < 99)
                count++;
            rel       = 1'b0;
            brk_after = 1'b0;
            last_make = code;
        end
    endtask

    task automatic send_bits(logic [10:0] bits, int nbits);
        for (int i = 0; i < nbits; i++) begin
            ps2_data = bits[i];
            repeat (HALF) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (HALF) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (SETTLE) @(negedge clk);
    endtask

    task automatic send_key(logic [7:0] code);
        send_bits(frame_bits(code, 0), 11);
        model_frame(code);
    endtask

    task automatic check_display(string name);
        if (segs !== model_segs())
            report_value({name, " display"}, model_segs(), segs);
    endtask

    task automatic check_ready_low(string name);
        if (ready !== 1'b0)
            report_value({name, " ready"}, 0, ready);
    endtask

    task automatic pop_and_check(string name);
        int n;
        n = 0;
        while (!ready && n < SETTLE) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            report_error({name, ": ready stayed low while a code was expected"});
        end else begin
            if (key_code !== exp_q[0])
                report_value({name, " key_code"}, exp_q[0], key_code);
            disp_checks++;
            if (segs !== model_segs())
                disp_errors++;
            check_display(name);
            pop = 1'b1;
            @(negedge clk);
            pop = 1'b0;
        end
        void'(exp_q.pop_front());
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == test_start) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    initial begin
        int         n;
        int         sel;
        logic [7:0] k;
        rst_n = 1'b0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        pop = 1'b0;
        errors = 0;
        test_start = 0;
        tests_run = 0;
        tests_bad = 0;
        disp_checks = 0;
        disp_errors = 0;
        count = 0;
        in_break = 1'b0;
        rel = 1'b0;
        exp_ovf = 1'b0;
        last_make = 8'h00;
        brk_after = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        n = 1 + rand_below(7);
        repeat (n) send_key(random_key());
        while (exp_q.size() > 0)
            pop_and_check("in_order");
        check_ready_low("in_order");
        if (overflow !== exp_ovf)
            report_value("in_order overflow", exp_ovf, overflow);
        end_test("in_order");

        repeat (6) begin
            k = random_key();
            send_key(k);
            pop_and_check("break_filter");
            send_key(8'hF0);
            check_ready_low("break_filter");
            check_display("break_filter");  // head digits dark until the next make.
            send_key(k);
            check_ready_low("break_filter");
            check_display("break_filter");
        end
        end_test("break_filter");

        repeat (150) begin
            sel = rand_below(4);
            if (sel < 2) begin
                send_key(random_key());
            end else if (sel == 2) begin
                send_key(last_make);  // typematic repeat.
            end else begin
                send_key(8'hF0);
                send_key(last_make);
                send_key(last_make);
            end
            pop_and_check("press_count");
        end
        if (count != 99)
            report_error("press count never reached saturation in this run");
        end_test("press_count");

        for (int b = 1; b <= 3; b++) begin
            send_bits(frame_bits(random_key(), b), 11);
            check_ready_low("bad_frame");
        end
        end_test("bad_frame");

        send_bits(frame_bits(random_key(), 0), 5);
        repeat (IDLE_HOLD) @(negedge clk);
        send_key(random_key());
        pop_and_check("stalled_frame");
        check_ready_low("stalled_frame");
        end_test("stalled_frame");

        repeat (10) send_key(random_key());
        if (overflow !== exp_ovf)
            report_value("overflow flag", exp_ovf, overflow);
        while (exp_q.size() > 0)
            pop_and_check("overflow");
        check_ready_low("overflow");
        end_test("overflow");

        tests_run++;
        if (disp_errors != 0)
            tests_bad++;
        $display("display: %0d codes checked, %0d errors", disp_checks, disp_errors);

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* hdl/ps2_kbd_top.sv */
module ps2_kbd_top #(
    parameter int FIFO_DEPTH  = 8,
    parameter int IDLE_CYCLES = 2000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ps2_clk,
    input  logic                    ps2_data,
    input  logic                    pop,
    output ps2_kbd_pkg::scan_code_t key_code,
    output logic                    ready,
    output logic                    overflow,
    output ps2_kbd_pkg::seg_bank_t  segs
);

    logic                    fall_edge;
    logic                    busy;
    logic                    stall;
    ps2_kbd_pkg::ps2_frame_t frame;
    logic                    push;
    ps2_kbd_pkg::scan_code_t push_code;
    logic                    release_seen;
    logic [6:0]              press_count;

    ps2_frame_rx ps2_frame_rx_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .stall     (stall),
        .fall_edge (fall_edge),
        .busy      (busy),
        .frame     (frame)
    );

    ps2_idle_timer #(
        .IDLE_CYCLES (IDLE_CYCLES)
    ) ps2_idle_timer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .fall_edge (fall_edge),
        .busy      (busy),
        .stall     (stall)
    );

    make_break_fsm make_break_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame        (frame),
        .push         (push),
        .push_code    (push_code),
        .release_seen (release_seen),
        .press_count  (press_count)
    );

    key_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) key_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_code (push_code),
        .pop       (pop),
        .head_code (key_code),
        .ready     (ready),
        .overflow  (overflow)
    );

    key_display key_display_inst (
        .head_code    (key_code),
        .release_seen (release_seen),
        .press_count  (press_count),
        .segs         (segs)
    );

endmodule

/* hdl/key_display.sv */
module key_display (
    input  ps2_kbd_pkg::scan_code_t head_code,
    input  logic                    release_seen,
    input  logic [6:0]              press_count,
    output ps2_kbd_pkg::seg_bank_t  segs
);

    logic [7:0] ascii;
    logic [7:0] asc_mod;
    logic [3:0] asc_ones;
    logic [3:0] asc_tens;
    logic [3:0] cnt_ones;
    logic [3:0] cnt_tens;

    always_comb begin
        ascii    = ps2_kbd_pkg::scan_to_ascii(head_code);
        asc_mod  = ascii % 8'd100;  // only two digits fit.
        asc_ones = 4'(asc_mod % 8'd10);
        asc_tens = 4'(asc_mod / 8'd10);
        cnt_ones = 4'(press_count % 7'd10);
        cnt_tens = 4'(press_count / 7'd10);
    end

    always_comb begin
        if (release_seen) begin
            // key is up, so the code digits go dark.
            segs.hex_lo   = ps2_kbd_pkg::SEG_BLANK;
            segs.hex_hi   = ps2_kbd_pkg::SEG_BLANK;
            segs.asc_ones = ps2_kbd_pkg::SEG_BLANK;
            segs.asc_tens = ps2_kbd_pkg::SEG_BLANK;
        end else begin
            segs.hex_lo   = ps2_kbd_pkg::seg_digit(head_code[3:0]);
            segs.hex_hi   = ps2_kbd_pkg::seg_digit(head_code[7:4]);
            segs.asc_ones = ps2_kbd_pkg::seg_digit(asc_ones);
            segs.asc_tens = ps2_kbd_pkg::seg_digit(asc_tens);
        end
        segs.cnt_ones = ps2_kbd_pkg::seg_digit(cnt_ones);
        segs.cnt_tens = ps2_kbd_pkg::seg_digit(cnt_tens);
    end

endmodule

/* hdl/key_fifo.sv */
module key_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  ps2_kbd_pkg::scan_code_t push_code,
    input  logic                    pop,
    output ps2_kbd_pkg::scan_code_t head_code,
    output logic                    ready,
    output logic                    overflow
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    ps2_kbd_pkg::scan_code_t mem [FIFO_DEPTH];

    // extra msb tells a full queue from an empty one.
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            empty;
    logic            full;
    logic            do_push;
    logic            do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && full)
                overflow <= 1'b1;  // sticky until reset.
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr[ADDR_W-1:0]] <= push_code;
    end

    assign head_code = mem[rd_ptr[ADDR_W-1:0]];
    assign ready     = !empty;

endmodule

/* hdl/make_break_fsm.sv */
module make_break_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ps2_kbd_pkg::ps2_frame_t frame,
    output logic                    push,
    output ps2_kbd_pkg::scan_code_t push_code,
    output logic                    release_seen,
    output logic [6:0]              press_count
);

    typedef enum logic {
        MAKE,
        BREAK
    } state_t;

    state_t                  state;
    ps2_kbd_pkg::scan_code_t last_make;
    logic                    break_after;  // a release followed last_make.
    logic                    new_press;

    // a repeat is the same make code with no release in between.
    assign new_press = (frame.code != last_make) || break_after;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= MAKE;
            push         <= 1'b0;
            release_seen <= 1'b0;
            press_count  <= 7'd0;
            break_after  <= 1'b1;  // first make after reset always counts.
        end else begin
            push <= 1'b0;
            if (frame.valid) begin
                case (state)
                    MAKE: begin
                        if (frame.code == ps2_kbd_pkg::BREAK_PREFIX) begin
                            state        <= BREAK;
                            release_seen <= 1'b1;
                            break_after  <= 1'b1;
                        end else begin
                            push         <= 1'b1;
                            release_seen <= 1'b0;
                            break_after  <= 1'b0;
                            if (new_press && press_count != ps2_kbd_pkg::COUNT_MAX)
                                press_count <= press_count + 7'd1;
                        end
                    end
                    default: begin
                        state <= MAKE;  // released key code is swallowed.
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame.valid && state == MAKE && frame.code != ps2_kbd_pkg::BREAK_PREFIX) begin
            push_code <= frame.code;
            last_make <= frame.code;
        end
    end

endmodule

/* hdl/ps2_idle_timer.sv */
module ps2_idle_timer #(
    parameter int IDLE_CYCLES = 2000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic fall_edge,
    input  logic busy,
    output logic stall
);

    localparam int CNT_W = $clog2(IDLE_CYCLES + 1);

    logic [CNT_W-1:0] idle_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idle_cnt <= '0;
            stall    <= 1'b0;
        end else begin
            stall <= 1'b0;
            if (fall_edge || !busy) begin
                idle_cnt <= '0;  // only a partial frame can stall.
            end else if (idle_cnt == CNT_W'(IDLE_CYCLES - 1)) begin
                idle_cnt <= '0;
                stall    <= 1'b1;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/ps2_frame_rx.sv */
module ps2_frame_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ps2_clk,
    input  logic                   ps2_data,
    input  logic                   stall,
    output logic                   fall_edge,
    output logic                   busy,
    output ps2_kbd_pkg::ps2_frame_t frame
);

    logic [2:0] clk_sync;   // two sync stages plus the edge register.
    logic [1:0] data_sync;
    logic [3:0] bit_cnt;
    logic [9:0] shifter;    // start, data, parity. stop bit is checked live.
    logic       last_bit;
    logic       frame_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync  <= 3'b111;  // keyboard clock idles high.
            data_sync <= 2'b11;
            fall_edge <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            fall_edge <= clk_sync[2] & ~clk_sync[1];
        end
    end

    assign last_bit = (bit_cnt == 4'd10);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= 4'd0;
        end else if (stall) begin
            // an edge arriving with the stall starts a fresh frame.
            bit_cnt <= {3'b000, fall_edge};
        end else if (fall_edge) begin
            bit_cnt <= last_bit ? 4'd0 : bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (fall_edge)
            shifter <= {data_sync[1], shifter[9:1]};  // lsb first on the wire.
    end

    // start low, odd parity over data and parity, stop high.
    assign frame_ok = ~shifter[0] & (^shifter[9:1]) & data_sync[1];

    assign busy        = (bit_cnt != 4'd0);
    assign frame.valid = fall_edge & last_bit & frame_ok;
    assign frame.code  = shifter[8:1];

endmodule

/* hdl/ps2_kbd_pkg.sv */
package ps2_kbd_pkg;

    typedef logic [7:0] scan_code_t;

    typedef struct packed {
        logic       valid;  // one-cycle strobe.
        scan_code_t code;
    } ps2_frame_t;

    // active-low patterns, bit 6 is segment a.
    typedef struct packed {
        logic [6:0] hex_lo;
        logic [6:0] hex_hi;
        logic [6:0] asc_ones;
        logic [6:0] asc_tens;
        logic [6:0] cnt_ones;
        logic [6:0] cnt_tens;
    } seg_bank_t;

    localparam scan_code_t BREAK_PREFIX = 8'hF0;
    localparam logic [6:0] COUNT_MAX    = 7'd99;
    localparam logic [6:0] SEG_BLANK    = 7'b1111111;

    function automatic logic [6:0] seg_digit(input logic [3:0] value);
        case (value)
            4'h0: seg_digit = 7'b0000001;
            4'h1: seg_digit = 7'b1001111;
            4'h2: seg_digit = 7'b0010010;
            4'h3: seg_digit = 7'b0000110;
            4'h4: seg_digit = 7'b1001100;
            4'h5: seg_digit = 7'b0100100;
            4'h6: seg_digit = 7'b1100000;
            4'h7: seg_digit = 7'b0001111;
            4'h8: seg_digit = 7'b0000000;
            4'h9: seg_digit = 7'b0001100;
            4'hA: seg_digit = 7'b0001000;
            4'hB: seg_digit = 7'b1100000;  // lower case b.
            4'hC: seg_digit = 7'b0110001;
            4'hD: seg_digit = 7'b1000010;
            4'hE: seg_digit = 7'b0110000;
            default: seg_digit = 7'b0111000;
        endcase
    endfunction

    // scan set 2 make codes for digits and letters only.
    function automatic logic [7:0] scan_to_ascii(input scan_code_t code);
        case (code)
            8'h45: scan_to_ascii = 8'd48;
            8'h16: scan_to_ascii = 8'd49;
            8'h1E: scan_to_ascii = 8'd50;
            8'h26: scan_to_ascii = 8'd51;
            8'h25: scan_to_ascii = 8'd52;
            8'h2E: scan_to_ascii = 8'd53;
            8'h36: scan_to_ascii = 8'd54;
            8'h3D: scan_to_ascii = 8'd55;
            8'h3E: scan_to_ascii = 8'd56;
            8'h46: scan_to_ascii = 8'd57;
            8'h1C: scan_to_ascii = 8'd65;
            8'h32: scan_to_ascii = 8'd66;
            8'h21: scan_to_ascii = 8'd67;
            8'h23: scan_to_ascii = 8'd68;
            8'h24: scan_to_ascii = 8'd69;
            8'h2B: scan_to_ascii = 8'd70;
            8'h34: scan_to_ascii = 8'd71;
            8'h33: scan_to_ascii = 8'd72;
            8'h43: scan_to_ascii = 8'd73;
            8'h3B: scan_to_ascii = 8'd74;
            8'h42: scan_to_ascii = 8'd75;
            8'h4B: scan_to_ascii = 8'd76;
            8'h3A: scan_to_ascii = 8'd77;
            8'h31: scan_to_ascii = 8'd78;
            8'h44: scan_to_ascii = 8'd79;
            8'h4D: scan_to_ascii = 8'd80;
            8'h15: scan_to_ascii = 8'd81;
            8'h2D: scan_to_ascii = 8'd82;
            8'h1B: scan_to_ascii = 8'd83;
            8'h2C: scan_to_ascii = 8'd84;
            8'h3C: scan_to_ascii = 8'd85;
            8'h2A: scan_to_ascii = 8'd86;
            8'h1D: scan_to_ascii = 8'd87;
            8'h22: scan_to_ascii = 8'd88;
            8'h35: scan_to_ascii = 8'd89;
            8'h1A: scan_to_ascii = 8'd90;
            default: scan_to_ascii = 8'd0;
        endcase
    endfunction

endpackage
